//--- vlog.f
src/dma_pkg.sv
src/dma_req_intake.sv
src/dma_domain_checker.sv
src/dma_copy_engine.sv
src/dma_resp_sender.sv
src/dma_guard_top.sv
test/dma_guard_monitor.sv
test/tb_dma_guard.sv

//--- Makefile
RTL = src/dma_pkg.sv src/dma_req_intake.sv src/dma_domain_checker.sv \
      src/dma_copy_engine.sv src/dma_resp_sender.sv src/dma_guard_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module dma_guard_top $(RTL)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_dma_guard -o tb_dma_guard
	./obj_dir/tb_dma_guard | tee sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- test/tb_dma_guard.sv
// dma guard testbench: clock, reset, memory model, stimulus table, four-phase driver and responder
`timescale 1ns/100ps
`default_nettype none

module tb_dma_guard;

	localparam int half_period    = 20;
	localparam int reset_cycles   = 5;
	localparam int timeout_margin = 100;
	localparam int n_tests        = 10;

	// one table entry
	typedef struct packed {
		dma_pkg::level_t   chan;
		dma_pkg::dma_req_t req;
		logic [3:0]        ack_dly;
		logic              b2b;
	} test_t;

	// ------------------------------
	// stimulus table
	// ------------------------------
	// chan, {opaque, level, src, dest, len}, ack delay, back to back
	localparam test_t tests [n_tests] = '{
		// level above channel, source wraps past ff
		'{2'd1, '{8'h11, 2'd3, 8'hf8, 8'h40, 4'd12}, 4'd0, 1'b0},
		// equal level, destination wraps
		'{2'd2, '{8'h22, 2'd2, 8'h10, 8'hfc, 4'd6}, 4'd1, 1'b0},
		// below channel
		'{2'd3, '{8'h33, 2'd1, 8'h20, 8'h60, 4'd5}, 4'd0, 1'b0},
		'{2'd2, '{8'h44, 2'd0, 8'h00, 8'h00, 4'd15}, 4'd2, 1'b0},
		// empty block
		'{2'd0, '{8'h55, 2'd2, 8'h30, 8'h70, 4'd0}, 4'd0, 1'b0},
		// burst with slow ack, entry 7 reads what entry 5 wrote
		'{2'd1, '{8'h61, 2'd1, 8'h80, 8'h90, 4'd3}, 4'd9, 1'b0},
		'{2'd1, '{8'h62, 2'd0, 8'h84, 8'hc0, 4'd4}, 4'd9, 1'b1},
		'{2'd1, '{8'h63, 2'd3, 8'h90, 8'ha0, 4'd2}, 4'd9, 1'b1},
		'{2'd1, '{8'h64, 2'd2, 8'h00, 8'h00, 4'd0}, 4'd9, 1'b1},
		'{2'd1, '{8'h65, 2'd1, 8'ha0, 8'h85, 4'd4}, 4'd9, 1'b1}
	};

	logic                       clk = 1'b0;
	logic                       reset;
	dma_pkg::level_t            chan_level;
	logic                       req_valid;
	dma_pkg::dma_req_t          req_in;
	logic                       req_ack;
	logic                       resp_valid;
	dma_pkg::dma_resp_t         resp_out;
	logic                       resp_ack;
	logic [dma_pkg::addr_w-1:0] mem_rd_addr;
	logic [dma_pkg::data_w-1:0] mem_rd_data;
	logic                       mem_wr_en;
	dma_pkg::mem_wr_t           mem_wr;

	// external memory model
	logic [dma_pkg::data_w-1:0] mem [256];
	int seed;
	// ack delay of each request, in send order
	int ack_delays [$];
	int ack_wait;
	int sent = 0;
	int acked = 0;
	int cycles = 0;
	int cycle_limit;
	int errs;

	always #half_period clk = ~clk;

	dma_guard_top #(
		.ADDR_W (dma_pkg::addr_w),
		.DATA_W (dma_pkg::data_w)
	) dut_i (
		.clk         (clk),
		.reset       (reset),
		.chan_level  (chan_level),
		.req_valid   (req_valid),
		.req_in      (req_in),
		.req_ack     (req_ack),
		.resp_valid  (resp_valid),
		.resp_out    (resp_out),
		.resp_ack    (resp_ack),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data),
		.mem_wr_en   (mem_wr_en),
		.mem_wr      (mem_wr)
	);

	dma_guard_monitor mon_i (
		.clk         (clk),
		.reset       (reset),
		.chan_level  (chan_level),
		.req_in      (req_in),
		.req_ack     (req_ack),
		.resp_valid  (resp_valid),
		.resp_out    (resp_out),
		.resp_ack    (resp_ack),
		.mem_rd_addr (mem_rd_addr),
		.mem_wr_en   (mem_wr_en),
		.mem_wr      (mem_wr)
	);

	// ------------------------------
	// memory model
	// ------------------------------
	initial begin
		seed = 10;
		for (int a = 0; a < 256; a++)
			mem[a] <= 16'($random(seed));
	end

	// read data comes back in the same cycle
	assign mem_rd_data = mem[mem_rd_addr];

	always @(posedge clk) begin
		if (mem_wr_en)
			mem[mem_wr.addr] <= mem_wr.data;
	end

	// budget per test, a copy costs two cycles per word
	function automatic int run_limit();
		int sum;
		sum = timeout_margin;
		for (int i = 0; i < n_tests; i++)
			sum += 2 * int'(tests[i].req.len) + 20;
		return sum;
	endfunction

	// full four-phase cycle on the request link, starts and ends on a falling edge
	task automatic send_request(input dma_pkg::dma_req_t r);
		req_in    = r;
		req_valid = 1'b1;
		@(negedge clk);
		while (!req_ack)
			@(negedge clk);
		req_valid = 1'b0;
		while (req_ack)
			@(negedge clk);
		sent++;
	endtask

	// wait until every request sent so far has been answered
	task automatic wait_drain();
		while (acked < sent)
			@(negedge clk);
	endtask

	// ------------------------------
	// response responder
	// ------------------------------
	always begin
		@(negedge clk);
		if (resp_valid && !resp_ack) begin
			ack_wait = (ack_delays.size() > 0) ? ack_delays.pop_front() : 0;
			repeat (ack_wait) @(negedge clk);
			resp_ack = 1'b1;
			while (resp_valid)
				@(negedge clk);
			resp_ack = 1'b0;
			acked++;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		reset       = 1'b1;
		chan_level  = 2'd0;
		req_valid   = 1'b0;
		req_in      = '0;
		resp_ack    = 1'b0;
		cycle_limit = run_limit();
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// quiet window after reset, nothing may come out
		repeat (8) @(negedge clk);
		for (int i = 0; i < n_tests; i++) begin
			// level only changes with nothing in flight
			if (!tests[i].b2b || tests[i].chan != chan_level)
				wait_drain();
			chan_level = tests[i].chan;
			ack_delays.push_back(int'(tests[i].ack_dly));
			send_request(tests[i].req);
		end
		wait_drain();
		repeat (5) @(negedge clk);
		errs = mon_i.report_counts();
		if (errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/dma_guard_monitor.sv
// dma guard monitor: predicts memory writes and responses from accepted requests and compares
`timescale 1ns/100ps
`default_nettype none

module dma_guard_monitor (
	input wire logic                       clk,
	input wire logic                       reset,
	input wire dma_pkg::level_t            chan_level,
	input wire dma_pkg::dma_req_t          req_in,
	input wire logic                       req_ack,
	input wire logic                       resp_valid,
	input wire dma_pkg::dma_resp_t         resp_out,
	input wire logic                       resp_ack,
	input wire logic [dma_pkg::addr_w-1:0] mem_rd_addr,
	input wire logic                       mem_wr_en,
	input wire dma_pkg::mem_wr_t           mem_wr
);

	// one predicted write with the read that feeds it, tagged with its test
	typedef struct packed {
		logic [7:0]                 test;
		logic [dma_pkg::addr_w-1:0] src;
		dma_pkg::mem_wr_t           wr;
	} exp_wr_t;

	// own copy of the memory, filled like the model
	logic [dma_pkg::data_w-1:0] model [256];
	exp_wr_t                    wr_q [$];
	dma_pkg::dma_resp_t         resp_q [$];
	logic                       bad [256];
	int seed;
	int accepted = 0;
	int delivered = 0;
	int checked = 0;
	int passed = 0;
	int failed = 0;
	int errors = 0;
	logic ack_q;
	logic valid_q;
	logic rack_q;
	// read address of the previous cycle
	logic [dma_pkg::addr_w-1:0] rd_addr_q;

	initial begin
		seed = 10;
		for (int a = 0; a < 256; a++) begin
			model[a] = 16'($random(seed));
			bad[a]   = 1'b0;
		end
	end

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got,
		input int n);
		$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
		errors++;
		bad[n] = 1'b1;
	endtask

	// ------------------------------
	// prediction
	// ------------------------------
	task automatic predict(input dma_pkg::dma_req_t r);
		dma_pkg::dma_resp_t e;
		exp_wr_t w;
		logic [dma_pkg::addr_w-1:0] s;
		e.opaque = r.opaque;
		e.level  = r.level;
		// equal or higher level passes
		e.status = (r.level >= chan_level) ? dma_pkg::st_done : dma_pkg::st_denied;
		resp_q.push_back(e);
		if (e.status == dma_pkg::st_done) begin
			// word by word, so overlapping blocks see earlier writes
			for (int i = 0; i < int'(r.len); i++) begin
				s            = r.src + 8'(i);
				w.test       = 8'(accepted);
				w.src        = s;
				w.wr.addr    = r.dest + 8'(i);
				w.wr.data    = model[s];
				model[w.wr.addr] = w.wr.data;
				wr_q.push_back(w);
			end
		end
		accepted++;
		// sender, checker and intake hold one request each
		if (accepted - delivered > 3) begin
			$display("error: req_ack given at %0t while the intake was already full", $time);
			errors++;
		end
	endtask

	task automatic check_write();
		exp_wr_t w;
		if (wr_q.size() == 0) begin
			$display("error: memory write to %h at %0t with no write expected", mem_wr.addr, $time);
			errors++;
		end else begin
			w = wr_q.pop_front();
			// the word is read in the cycle before its write
			if (rd_addr_q != w.src)
				mismatch("mem_rd_addr", 32'(w.src), 32'(rd_addr_q), int'(w.test));
			if (mem_wr.addr != w.wr.addr)
				mismatch("mem_wr.addr", 32'(w.wr.addr), 32'(mem_wr.addr), int'(w.test));
			if (mem_wr.data != w.wr.data)
				mismatch("mem_wr.data", 32'(w.wr.data), 32'(mem_wr.data), int'(w.test));
		end
	endtask

	task automatic check_resp();
		dma_pkg::dma_resp_t e;
		if (resp_q.size() == 0) begin
			$display("error: response with tag %h arrived with no request outstanding",
				resp_out.opaque);
			errors++;
		end else begin
			e = resp_q.pop_front();
			if (resp_out.opaque != e.opaque)
				mismatch("resp_out.opaque", 32'(e.opaque), 32'(resp_out.opaque), checked);
			if (resp_out.level != e.level)
				mismatch("resp_out.level", 32'(e.level), 32'(resp_out.level), checked);
			if (resp_out.status != e.status)
				mismatch("resp_out.status", 32'(e.status), 32'(resp_out.status), checked);
			// writes of this test still missing
			while (wr_q.size() > 0 && int'(wr_q[0].test) == checked) begin
				$display("error: test %0d answered before write to %h happened",
					checked, wr_q[0].wr.addr);
				void'(wr_q.pop_front());
				errors++;
				bad[checked] = 1'b1;
			end
			$display("test %0d: tag %h level %0d %s %s", checked, e.opaque, e.level,
				(e.status == dma_pkg::st_done) ? "done" : "denied",
				bad[checked] ? "failed" : "ok");
			if (bad[checked])
				failed++;
			else
				passed++;
			checked++;
		end
	endtask

	// ------------------------------
	// sampling on the rising edge
	// ------------------------------
	always @(posedge clk) begin
		if (reset) begin
			ack_q     <= 1'b0;
			valid_q   <= 1'b0;
			rack_q    <= 1'b0;
			rd_addr_q <= '0;
		end else begin
			// response cycle closes when ack falls
			if (rack_q && !resp_ack)
				delivered++;
			if (req_ack && !ack_q)
				predict(req_in);
			if (mem_wr_en)
				check_write();
			if (resp_valid && !valid_q)
				check_resp();
			ack_q     <= req_ack;
			valid_q   <= resp_valid;
			rack_q    <= resp_ack;
			rd_addr_q <= mem_rd_addr;
		end
	end

	// closing counts, returns the number of problems
	function automatic int report_counts();
		if (resp_q.size() != 0) begin
			$display("error: %0d response(s) never arrived", resp_q.size());
			errors += resp_q.size();
		end
		if (wr_q.size() != 0) begin
			$display("error: %0d expected memory write(s) never happened", wr_q.size());
			errors += wr_q.size();
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d", checked, passed, failed, errors);
		return errors + failed;
	endfunction

endmodule

`default_nettype wire

//--- src/dma_guard_top.sv
// dma guard top: request intake, domain checker, copy engine and response sender
`timescale 1ns/100ps
`default_nettype none

module dma_guard_top #(
	parameter int ADDR_W = dma_pkg::addr_w,
	parameter int DATA_W = dma_pkg::data_w
) (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire dma_pkg::level_t    chan_level,
	// network request link
	input  wire logic               req_valid,
	input  wire dma_pkg::dma_req_t  req_in,
	output logic                    req_ack,
	// network response link
	output logic                    resp_valid,
	output dma_pkg::dma_resp_t      resp_out,
	input  wire logic               resp_ack,
	// external memory
	output logic [ADDR_W-1:0]       mem_rd_addr,
	input  wire logic [DATA_W-1:0]  mem_rd_data,
	output logic                    mem_wr_en,
	output dma_pkg::mem_wr_t        mem_wr
);

	// ------------------------------
	// internal links
	// ------------------------------
	logic               pend_valid;
	dma_pkg::dma_req_t  pend_req;
	logic               pend_ready;
	logic               copy_start;
	dma_pkg::dma_req_t  copy_req;
	logic               copy_done;
	logic               chk_resp_valid;
	dma_pkg::dma_resp_t chk_resp;
	logic               chk_resp_ready;

	dma_req_intake u_intake (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_in     (req_in),
		.req_ack    (req_ack),
		.pend_valid (pend_valid),
		.pend_req   (pend_req),
		.pend_ready (pend_ready)
	);

	dma_domain_checker u_checker (
		.clk        (clk),
		.reset      (reset),
		.pend_valid (pend_valid),
		.pend_req   (pend_req),
		.pend_ready (pend_ready),
		.chan_level (chan_level),
		.copy_start (copy_start),
		.copy_req   (copy_req),
		.copy_done  (copy_done),
		.resp_valid (chk_resp_valid),
		.resp       (chk_resp),
		.resp_ready (chk_resp_ready)
	);

	dma_copy_engine #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W)
	) u_engine (
		.clk         (clk),
		.reset       (reset),
		.copy_start  (copy_start),
		.copy_req    (copy_req),
		.copy_done   (copy_done),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data),
		.mem_wr_en   (mem_wr_en),
		.mem_wr      (mem_wr)
	);

	dma_resp_sender u_sender (
		.clk           (clk),
		.reset         (reset),
		.resp_valid_in (chk_resp_valid),
		.resp_in       (chk_resp),
		.resp_ready    (chk_resp_ready),
		.resp_valid    (resp_valid),
		.resp_out      (resp_out),
		.resp_ack      (resp_ack)
	);

	// struct fields are sized by the package, port widths by the parameters
	a_width_match: assert property (
		@(posedge clk)
		(ADDR_W == dma_pkg::addr_w) && (DATA_W == dma_pkg::data_w)
	);

endmodule

`default_nettype wire

//--- src/dma_resp_sender.sv
// response sender: holds one response and returns it over the four-phase network link
`timescale 1ns/100ps
`default_nettype none

module dma_resp_sender (
	input  wire logic               clk,
	input  wire logic               reset,
	// from checker, valid/ready
	input  wire logic               resp_valid_in,
	input  wire dma_pkg::dma_resp_t resp_in,
	output logic                    resp_ready,
	// network side, four-phase
	output logic                    resp_valid,
	output dma_pkg::dma_resp_t      resp_out,
	input  wire logic               resp_ack
);

	typedef enum logic [1:0] {
		r_idle,
		// valid high, waiting for ack
		r_send,
		// valid low, waiting for ack to fall
		r_release
	} state_t;

	state_t state;

	// ------------------------------
	// four-phase sequence
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= r_idle;
		end else begin
			case (state)
				r_idle:
					if (resp_valid_in)
						state <= r_send;
				r_send:
					if (resp_ack)
						state <= r_release;
				r_release:
					if (!resp_ack)
						state <= r_idle;
				default:
					state <= r_idle;
			endcase
		end
	end

	// response payload, captured when taken
	always_ff @(posedge clk) begin
		if (state == r_idle && resp_valid_in)
			resp_out <= resp_in;
	end

	// only ready when no four-phase cycle is open, which back-pressures the checker
	assign resp_ready = state == r_idle;
	assign resp_valid = state == r_send;

	// the core may only acknowledge a response we are offering
	a_ack_after_valid: assert property (
		@(posedge clk) disable iff (reset)
		$rose(resp_ack) |-> resp_valid
	);

endmodule

`default_nettype wire

//--- src/dma_copy_engine.sv
// copy engine: moves a block of words from source to destination, one read and one write per word
`timescale 1ns/100ps
`default_nettype none

module dma_copy_engine #(
	parameter int ADDR_W = 8,
	parameter int DATA_W = 16
) (
	input  wire logic              clk,
	input  wire logic              reset,
	// from checker
	input  wire logic              copy_start,
	input  wire dma_pkg::dma_req_t copy_req,
	output logic                   copy_done,
	// memory read, data returns in the same cycle
	output logic [ADDR_W-1:0]      mem_rd_addr,
	input  wire logic [DATA_W-1:0] mem_rd_data,
	// memory write
	output logic                   mem_wr_en,
	output dma_pkg::mem_wr_t       mem_wr
);

	// ------------------------------
	// state
	// ------------------------------
	typedef enum logic [1:0] {
		e_idle,
		e_read,
		e_write,
		e_done
	} state_t;

	state_t            state;
	// block parameters latched at start
	logic [ADDR_W-1:0] src_q;
	logic [ADDR_W-1:0] dest_q;
	logic [3:0]        len_q;
	// word index within the block
	logic [3:0]        idx;
	// word fetched in the read cycle
	logic [DATA_W-1:0] data_q;
	logic              last_word;

	assign last_word = (idx + 4'd1) == len_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= e_idle;
			idx   <= 4'd0;
		end else begin
			case (state)
				e_idle:
					if (copy_start) begin
						idx <= 4'd0;
						// empty block finishes at once
						state <= (copy_req.len == 4'd0) ? e_done : e_read;
					end
				e_read:
					state <= e_write;
				e_write: begin
					idx   <= idx + 4'd1;
					state <= last_word ? e_done : e_read;
				end
				e_done:
					state <= e_idle;
				default:
					state <= e_idle;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (state == e_idle && copy_start) begin
			src_q  <= copy_req.src;
			dest_q <= copy_req.dest;
			len_q  <= copy_req.len;
		end
		if (state == e_read)
			data_q <= mem_rd_data;
	end

	// ------------------------------
	// memory port
	// ------------------------------
	// addresses wrap at 2**ADDR_W by plain truncation
	assign mem_rd_addr = src_q + ADDR_W'(idx);
	assign mem_wr_en   = state == e_write;
	assign copy_done   = state == e_done;

	always_comb begin
		mem_wr.addr = dest_q + ADDR_W'(idx);
		mem_wr.data = data_q;
	end

	// no write past the end of the block, so nothing strays between blocks
	a_write_in_block: assert property (
		@(posedge clk) disable iff (reset)
		mem_wr_en |-> (idx < len_q)
	);

endmodule

`default_nettype wire

//--- src/dma_domain_checker.sv
// domain checker: compares request level with channel level, runs the copy or denies it
`timescale 1ns/100ps
`default_nettype none

module dma_domain_checker (
	input  wire logic               clk,
	input  wire logic               reset,
	// from intake
	input  wire logic               pend_valid,
	input  wire dma_pkg::dma_req_t  pend_req,
	output logic                    pend_ready,
	// level of this dma channel
	input  wire dma_pkg::level_t    chan_level,
	// to copy engine
	output logic                    copy_start,
	output dma_pkg::dma_req_t       copy_req,
	input  wire logic               copy_done,
	// to response sender
	output logic                    resp_valid,
	output dma_pkg::dma_resp_t      resp,
	input  wire logic               resp_ready
);

	// ------------------------------
	// state
	// ------------------------------
	typedef enum logic [2:0] {
		s_idle,
		s_check,
		s_copy,
		s_wait,
		s_respond
	} state_t;

	state_t            state;
	state_t            state_next;
	// request under check
	dma_pkg::dma_req_t req_q;
	dma_pkg::status_t  status_q;
	logic              granted;

	// equal or higher privilege passes
	assign granted = req_q.level >= chan_level;

	always_ff @(posedge clk) begin
		if (reset)
			state <= s_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			s_idle:
				if (pend_valid)
					state_next = s_check;
			s_check:
				state_next = granted ? s_copy : s_respond;
			// copy_start is high for this one cycle
			s_copy:
				state_next = s_wait;
			s_wait:
				if (copy_done)
					state_next = s_respond;
			s_respond:
				// stalls here while the sender is busy
				if (resp_ready)
					state_next = s_idle;
			default:
				state_next = s_idle;
		endcase
	end

	// ------------------------------
	// request and verdict registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (state == s_idle && pend_valid)
			req_q <= pend_req;
		if (state == s_check)
			status_q <= granted ? dma_pkg::st_done : dma_pkg::st_denied;
	end

	// ------------------------------
	// outputs
	// ------------------------------
	assign pend_ready = state == s_idle;
	assign copy_start = state == s_copy;
	assign copy_req   = req_q;
	assign resp_valid = state == s_respond;

	// response echoes tag and level of the request
	always_comb begin
		resp.opaque = req_q.opaque;
		resp.level  = req_q.level;
		resp.status = status_q;
	end

	// a request below the channel level must never reach memory
	a_no_denied_copy: assert property (
		@(posedge clk) disable iff (reset)
		copy_start |-> (copy_req.level >= chan_level)
	);

endmodule

`default_nettype wire

//--- src/dma_req_intake.sv
// request intake: four-phase receiver holding one network request for the domain checker
`timescale 1ns/100ps
`default_nettype none

module dma_req_intake (
	input  wire logic              clk,
	input  wire logic              reset,
	// network side, four-phase
	input  wire logic              req_valid,
	input  wire dma_pkg::dma_req_t req_in,
	output logic                   req_ack,
	// checker side, valid/ready
	output logic                   pend_valid,
	output dma_pkg::dma_req_t      pend_req,
	input  wire logic              pend_ready
);

	// holding register is free now or frees on this edge
	logic hold_free;
	// new request seen and not yet acknowledged
	logic accept;

	assign hold_free = !pend_valid || pend_ready;
	assign accept    = req_valid && !req_ack && hold_free;

	// ------------------------------
	// handshake and holding state
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			req_ack    <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			// checker took the request
			if (pend_valid && pend_ready)
				pend_valid <= 1'b0;
			if (accept) begin
				// ack and capture in the same cycle
				req_ack    <= 1'b1;
				pend_valid <= 1'b1;
			end else if (req_ack && !req_valid) begin
				// sender dropped valid, close the four-phase cycle
				req_ack <= 1'b0;
			end
		end
	end

	// payload register, no reset needed
	always_ff @(posedge clk) begin
		if (accept)
			pend_req <= req_in;
	end

	// the core must hold its request until we acknowledge it
	a_req_stable: assert property (
		@(posedge clk) disable iff (reset)
		(req_valid && !req_ack) |=> (!req_valid || $stable(req_in))
	);

endmodule

`default_nettype wire

//--- src/dma_pkg.sv
// dma package: request, response, memory-write and status types for the dma security gate
`default_nettype none

package dma_pkg;

	// ------------------------------
	// widths
	// ------------------------------

	// memory address width, default for ADDR_W at the top level
	localparam int addr_w = 8;
	// memory word width, default for DATA_W at the top level
	localparam int data_w = 16;

	// ------------------------------
	// basic types
	// ------------------------------

	// security level, higher value means more privilege
	typedef logic [1:0] level_t;

	// outcome of one request
	typedef enum logic {
		st_done   = 1'b0,
		st_denied = 1'b1
	} status_t;

	// ------------------------------
	// network messages
	// ------------------------------

	// copy request from a core, 30 bits
	typedef struct packed {
		logic [7:0]        opaque;
		level_t            level;
		logic [addr_w-1:0] src;
		logic [addr_w-1:0] dest;
		// word count, zero copies nothing but still completes
		logic [3:0]        len;
	} dma_req_t;

	// response back to the core, 11 bits
	typedef struct packed {
		logic [7:0] opaque;
		level_t     level;
		status_t    status;
	} dma_resp_t;

	// write half of the memory port
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} mem_wr_t;

endpackage

`default_nettype wire
